/* hw/sweep_defs.svh */
// sweep analyzer widths, calibration constants and sweep timing
`ifndef SWEEP_DEFS_SVH
`define SWEEP_DEFS_SVH

// datapath widths
`define SAMPLE_W        14        // calibrated / dac sample
`define ADC_IN_W        16        // raw adc bus, 2 lsbs reserved
`define ADDR_W          8         // sweep step address
`define PHASE_W         32        // phase accumulator
`define TIMER_W         8         // dwell counter, must hold MEASURE_CYCLES

// stepped sweep
`define NUM_STEPS       8
`define PHASE_STEP      34359738  // base increment, ~fs/125 at step 0

// adc calibration, (code - offset) * gain >>> shift - bias
`define CAL_OFFSET      6690
`define CAL_GAIN        174
`define CAL_SHIFT       6
`define CAL_BIAS        4096

// dwell per step in adc_clk cycles
`define SETTLE_CYCLES   16
`define MEASURE_CYCLES  64

`endif

/* hw/sweep_pkg.sv */
// shared sample, address, phase, timer and sweep state types
`default_nettype none

`include "sweep_defs.svh"

package sweep_pkg;

  typedef logic signed [`SAMPLE_W-1:0] sample_t;  // two's complement sample
  typedef logic        [`ADDR_W-1:0]   addr_t;    // frequency step index
  typedef logic        [`PHASE_W-1:0]  phase_t;   // accumulator word
  typedef logic        [`TIMER_W-1:0]  timer_t;   // dwell length / count

  // sweep sequencer states
  typedef enum logic [2:0] {
    IDLE,
    SETTLE,   // stimulus running, response settling
    MEASURE,  // peak detectors tracking
    REPORT,   // results valid for one cycle
    DONE      // single cycle after last step
  } sweep_state_t;

  // full scale limits of a sample
  localparam sample_t SAMPLE_MAX = sample_t'((1 << (`SAMPLE_W-1)) - 1);
  localparam sample_t SAMPLE_MIN = sample_t'(-(1 << (`SAMPLE_W-1)));

endpackage

`default_nettype wire

/* hw/adc_front_end.sv */
// two-channel adc capture with negative-slope decode, resync and offset/gain calibration
`timescale 1ns/10ps
`default_nettype none

`include "sweep_defs.svh"

module adc_front_end
  import sweep_pkg::*;
(
  input  wire logic                 adc_clk,
  input  wire logic                 rst_n_i,
  input  wire logic [`ADC_IN_W-1:0] adc_a_i,   // raw word, channel a
  input  wire logic [`ADC_IN_W-1:0] adc_b_i,   // raw word, channel b
  output sample_t                   cal_a_o,
  output sample_t                   cal_b_o
);

  localparam int CAL_W = 25;  // wide enough for (code - offset) * gain

  localparam logic signed [CAL_W-1:0] CAL_OFF   = `CAL_OFFSET;
  localparam logic signed [CAL_W-1:0] CAL_MUL   = `CAL_GAIN;
  localparam logic signed [CAL_W-1:0] CAL_SUB   = `CAL_BIAS;
  localparam logic signed [CAL_W-1:0] SAT_HI    = SAMPLE_MAX;
  localparam logic signed [CAL_W-1:0] SAT_LO    = SAMPLE_MIN;

  logic [`ADC_IN_W-1:0] adc_in [2];  // channel 0 = a, 1 = b
  sample_t raw_q   [2];              // capture, lsbs dropped
  sample_t sync1_q [2];              // first resync stage, already decoded
  sample_t sync2_q [2];
  sample_t cal_q   [2];

  // offset, gain, shift, bias, then clip to 14 bits
  function automatic sample_t calibrate(input sample_t s);
    logic signed [CAL_W-1:0] v;
    v = s;                              // sign extend
    v = (v - CAL_OFF) * CAL_MUL;
    v = (v >>> `CAL_SHIFT) - CAL_SUB;
    if (v > SAT_HI)
      return SAMPLE_MAX;
    else if (v < SAT_LO)
      return SAMPLE_MIN;
    return sample_t'(v);
  endfunction

  assign adc_in[0] = adc_a_i;
  assign adc_in[1] = adc_b_i;

  //////////////////////////////////////////////////////////////////////
  // capture -> sync1 -> sync2 -> cal, 4 cycles total
  //////////////////////////////////////////////////////////////////////
  always_ff @(posedge adc_clk)
  begin
    if (!rst_n_i)
    begin
      for (int ch = 0; ch < 2; ch++)
      begin
        raw_q[ch]   <= '0;
        sync1_q[ch] <= '0;
        sync2_q[ch] <= '0;
        cal_q[ch]   <= '0;
      end
    end
    else
    begin
      for (int ch = 0; ch < 2; ch++)
      begin
        raw_q[ch]   <= adc_in[ch][`ADC_IN_W-1 -: `SAMPLE_W];  // 2 reserved lsbs out
        // neg-slope to 2's complement, keep msb, flip the rest
        sync1_q[ch] <= {raw_q[ch][`SAMPLE_W-1], ~raw_q[ch][`SAMPLE_W-2:0]};
        sync2_q[ch] <= sync1_q[ch];
        cal_q[ch]   <= calibrate(sync2_q[ch]);
      end
    end
  end

  assign cal_a_o = cal_q[0];
  assign cal_b_o = cal_q[1];

endmodule

`default_nettype wire

/* hw/sweep_fsm.sv */
// stepped sweep sequencer, settle / measure / report per frequency step
`timescale 1ns/10ps
`default_nettype none

`include "sweep_defs.svh"

module sweep_fsm
  import sweep_pkg::*;
(
  input  wire logic adc_clk,
  input  wire logic rst_n_i,
  input  wire logic start_i,          // one cycle strobe
  input  wire logic timer_expired_i,
  output logic      timer_load_o,
  output timer_t    timer_len_o,
  output logic      gen_en_o,         // stimulus running
  output addr_t     step_addr_o,
  output logic      meas_clear_o,
  output logic      meas_en_o,
  output logic      step_valid_o,
  output logic      busy_o,
  output logic      sweep_done_o
);

  localparam addr_t  LAST_ADDR   = addr_t'(`NUM_STEPS - 1);
  localparam timer_t SETTLE_LEN  = timer_t'(`SETTLE_CYCLES);
  localparam timer_t MEASURE_LEN = timer_t'(`MEASURE_CYCLES);

  sweep_state_t state_q, state_d;
  addr_t        addr_q;
  logic         last_step;   // current step is the final one
  logic         start_ok;    // start while not busy

  assign last_step = (addr_q == LAST_ADDR);
  assign start_ok  = start_i && (state_q == IDLE || state_q == DONE);

  always_comb
  begin
    state_d = state_q;
    case (state_q)
      IDLE, DONE: state_d = start_i ? SETTLE : IDLE;      // DONE lasts one cycle
      SETTLE:     if (timer_expired_i) state_d = MEASURE;
      MEASURE:    if (timer_expired_i) state_d = REPORT;
      REPORT:     state_d = last_step ? DONE : SETTLE;
      default:    state_d = IDLE;
    endcase
  end

  always_ff @(posedge adc_clk)
  begin
    if (!rst_n_i)
    begin
      state_q <= IDLE;
      addr_q  <= '0;
    end
    else
    begin
      state_q <= state_d;
      if (state_q == REPORT)
        addr_q <= last_step ? '0 : addr_q + addr_t'(1);  // wrap for next sweep
    end
  end

  // timer is loaded one cycle ahead of the phase it times
  assign timer_load_o = start_ok
                     || (state_q == SETTLE && timer_expired_i)
                     || (state_q == REPORT && !last_step);
  assign timer_len_o  = (state_q == SETTLE) ? MEASURE_LEN : SETTLE_LEN;

  assign gen_en_o     = (state_q == SETTLE) || (state_q == MEASURE) || (state_q == REPORT);
  assign meas_clear_o = (state_q == SETTLE) && timer_expired_i;  // entering MEASURE
  assign meas_en_o    = (state_q == MEASURE);
  assign step_valid_o = (state_q == REPORT);
  assign sweep_done_o = (state_q == DONE);
  assign busy_o       = gen_en_o;   // low again in DONE
  assign step_addr_o  = addr_q;

  a_addr_range : assert property (@(posedge adc_clk) disable iff (!rst_n_i)
    addr_q <= LAST_ADDR);

endmodule

`default_nettype wire

/* hw/dwell_timer.sv */
// loadable down-counter with a one cycle expiry flag for settle and measure dwell
`timescale 1ns/10ps
`default_nettype none

`include "sweep_defs.svh"

module dwell_timer
  import sweep_pkg::*;
(
  input  wire logic   adc_clk,
  input  wire logic   rst_n_i,
  input  wire logic   timer_load_i,
  input  wire timer_t timer_len_i,
  output logic        timer_expired_o  // len cycles after load
);

  timer_t cnt_q;  // 0 = stopped

  always_ff @(posedge adc_clk)
  begin
    if (!rst_n_i)
      cnt_q <= '0;
    else if (timer_load_i)
      cnt_q <= timer_len_i;
    else if (cnt_q != '0)
      cnt_q <= cnt_q - timer_t'(1);
  end

  assign timer_expired_o = (cnt_q == timer_t'(1));  // last counted cycle

  // reload allowed only in the expiry cycle or when stopped
  a_no_early_load : assert property (@(posedge adc_clk) disable iff (!rst_n_i)
    timer_load_i |-> cnt_q <= timer_t'(1));

endmodule

`default_nettype wire

/* hw/phase_generator.sv */
// phase accumulator stimulus, triangle folded from the top phase bits
`timescale 1ns/10ps
`default_nettype none

`include "sweep_defs.svh"

module phase_generator
  import sweep_pkg::*;
(
  input  wire logic  adc_clk,
  input  wire logic  rst_n_i,
  input  wire logic  gen_en_i,
  input  wire addr_t step_addr_i,
  output sample_t    gen_sample_o   // -4096 .. 4095
);

  localparam phase_t BASE_INC = phase_t'(`PHASE_STEP);
  localparam phase_t QUARTER  = phase_t'(1) << (`PHASE_W - 2);  // 90 deg

  phase_t               acc_q;
  phase_t               inc;
  phase_t               shifted;   // quarter ahead so output starts at 0
  logic [`SAMPLE_W-1:0] ramp;
  logic [`SAMPLE_W-1:0] fold;      // unsigned up/down ramp
  sample_t              tri_s;

  // increment = (addr + 1) * base
  assign inc = (phase_t'(step_addr_i) + phase_t'(1)) * BASE_INC;

  always_ff @(posedge adc_clk)
  begin
    if (!rst_n_i)
      acc_q <= '0;
    else if (gen_en_i)
      acc_q <= acc_q + inc;
    else
      acc_q <= '0;   // phase restarts each sweep
  end

  //////////////////////////////////////////////////////////////////////
  // triangle shaping
  //////////////////////////////////////////////////////////////////////
  assign shifted = acc_q + QUARTER;
  assign ramp    = shifted[`PHASE_W-2 -: `SAMPLE_W];            // bits below msb
  assign fold    = shifted[`PHASE_W-1] ? ~ramp : ramp;           // second half runs down
  assign tri_s   = {~fold[`SAMPLE_W-1], fold[`SAMPLE_W-2:0]};    // offset binary to signed

  // halve, msb repeated
  assign gen_sample_o = {tri_s[`SAMPLE_W-1], tri_s[`SAMPLE_W-1:1]};

endmodule

`default_nettype wire

/* hw/peak_detector.sv */
// running min and max of both calibrated channels over a measure window
`timescale 1ns/10ps
`default_nettype none

`include "sweep_defs.svh"

module peak_detector
  import sweep_pkg::*;
(
  input  wire logic    adc_clk,
  input  wire logic    rst_n_i,
  input  wire logic    meas_clear_i,  // start of window
  input  wire logic    meas_en_i,
  input  wire sample_t cal_a_i,
  input  wire sample_t cal_b_i,
  output sample_t      max_a_o,
  output sample_t      min_a_o,
  output sample_t      max_b_o,
  output sample_t      min_b_o
);

  sample_t cal_in [2];
  sample_t max_q  [2];
  sample_t min_q  [2];

  assign cal_in[0] = cal_a_i;
  assign cal_in[1] = cal_b_i;

  always_ff @(posedge adc_clk)
  begin
    if (!rst_n_i || meas_clear_i)
    begin
      for (int ch = 0; ch < 2; ch++)
      begin
        max_q[ch] <= SAMPLE_MIN;  // any sample wins
        min_q[ch] <= SAMPLE_MAX;
      end
    end
    else if (meas_en_i)
    begin
      for (int ch = 0; ch < 2; ch++)
      begin
        if (cal_in[ch] > max_q[ch])
          max_q[ch] <= cal_in[ch];
        if (cal_in[ch] < min_q[ch])
          min_q[ch] <= cal_in[ch];
      end
    end
  end

  assign max_a_o = max_q[0];
  assign min_a_o = min_q[0];
  assign max_b_o = max_q[1];
  assign min_b_o = min_q[1];

  // once a sample is in, the window can no longer be inverted
  a_max_ge_min : assert property (@(posedge adc_clk) disable iff (!rst_n_i)
    meas_en_i && !meas_clear_i |=> max_a_o >= min_a_o && max_b_o >= min_b_o);

endmodule

`default_nettype wire

/* hw/dac_back_end.sv */
// dac channel a output, stimulus plus correction, saturated and neg-slope coded
`timescale 1ns/10ps
`default_nettype none

`include "sweep_defs.svh"

module dac_back_end
  import sweep_pkg::*;
(
  input  wire logic          adc_clk,
  input  wire logic          rst_n_i,
  input  wire sample_t       gen_sample_i,
  input  wire sample_t       ext_i,         // external correction
  output logic [`SAMPLE_W-1:0] dac_dat_o    // neg-slope code
);

  localparam logic [`SAMPLE_W-1:0] CODE_ZERO = {1'b0, {(`SAMPLE_W-1){1'b1}}};

  logic signed [`SAMPLE_W:0] sum;   // one guard bit
  sample_t                   sat;

  assign sum = gen_sample_i + ext_i;

  // top two bits differ -> overflow, clamp toward the sign
  assign sat = (sum[`SAMPLE_W] ^ sum[`SAMPLE_W-1])
             ? {sum[`SAMPLE_W], {(`SAMPLE_W-1){~sum[`SAMPLE_W]}}}
             : sum[`SAMPLE_W-1:0];

  //////////////////////////////////////////////////////////////////////
  // output register, signed to neg-slope
  //////////////////////////////////////////////////////////////////////
  always_ff @(posedge adc_clk)
  begin
    if (!rst_n_i)
      dac_dat_o <= CODE_ZERO;   // mid scale
    else
      dac_dat_o <= {sat[`SAMPLE_W-1], ~sat[`SAMPLE_W-2:0]};
  end

endmodule

`default_nettype wire

/* hw/sweep_analyzer_top.sv */
// stepped frequency response sweep, adc front end through peak detect and dac output
`timescale 1ns/10ps
`default_nettype none

`include "sweep_defs.svh"

module sweep_analyzer_top
  import sweep_pkg::*;
(
  input  wire logic                 adc_clk,
  input  wire logic                 rst_n_i,
  input  wire logic [`ADC_IN_W-1:0] adc_a_i,
  input  wire logic [`ADC_IN_W-1:0] adc_b_i,
  input  wire sample_t              ext_i,        // added to stimulus
  input  wire logic                 start_i,
  output logic [`SAMPLE_W-1:0]      dac_dat_o,
  output logic                      busy_o,
  output logic                      step_valid_o, // results valid
  output addr_t                     step_addr_o,
  output sample_t                   max_a_o,
  output sample_t                   min_a_o,
  output sample_t                   max_b_o,
  output sample_t                   min_b_o,
  output logic                      sweep_done_o
);

  logic    timer_load, timer_expired;
  timer_t  timer_len;
  logic    gen_en;
  logic    meas_clear, meas_en;
  sample_t cal_a, cal_b;
  sample_t gen_sample;

  //////////////////////////////////////////////////////////////////////
  // acquisition
  //////////////////////////////////////////////////////////////////////
  adc_front_end adc_front_end_i (
    .adc_clk (adc_clk), .rst_n_i (rst_n_i),
    .adc_a_i (adc_a_i), .adc_b_i (adc_b_i),
    .cal_a_o (cal_a),   .cal_b_o (cal_b)
  );

  peak_detector peak_detector_i (
    .adc_clk      (adc_clk),    .rst_n_i   (rst_n_i),
    .meas_clear_i (meas_clear), .meas_en_i (meas_en),
    .cal_a_i      (cal_a),      .cal_b_i   (cal_b),
    .max_a_o      (max_a_o),    .min_a_o   (min_a_o),
    .max_b_o      (max_b_o),    .min_b_o   (min_b_o)
  );

  //////////////////////////////////////////////////////////////////////
  // sequencing
  //////////////////////////////////////////////////////////////////////
  sweep_fsm sweep_fsm_i (
    .adc_clk         (adc_clk),       .rst_n_i      (rst_n_i),
    .start_i         (start_i),       .timer_expired_i (timer_expired),
    .timer_load_o    (timer_load),    .timer_len_o  (timer_len),
    .gen_en_o        (gen_en),        .step_addr_o  (step_addr_o),
    .meas_clear_o    (meas_clear),    .meas_en_o    (meas_en),
    .step_valid_o    (step_valid_o),  .busy_o       (busy_o),
    .sweep_done_o    (sweep_done_o)
  );

  dwell_timer dwell_timer_i (
    .adc_clk      (adc_clk),    .rst_n_i         (rst_n_i),
    .timer_load_i (timer_load), .timer_len_i     (timer_len),
    .timer_expired_o (timer_expired)
  );

  //////////////////////////////////////////////////////////////////////
  // stimulus out
  //////////////////////////////////////////////////////////////////////
  phase_generator phase_generator_i (
    .adc_clk  (adc_clk), .rst_n_i     (rst_n_i),
    .gen_en_i (gen_en),  .step_addr_i (step_addr_o),
    .gen_sample_o (gen_sample)
  );

  dac_back_end dac_back_end_i (
    .adc_clk      (adc_clk),    .rst_n_i (rst_n_i),
    .gen_sample_i (gen_sample), .ext_i   (ext_i),
    .dac_dat_o    (dac_dat_o)
  );

  // done only right after the report of the last step, never with it
  a_done_after_last : assert property (@(posedge adc_clk) disable iff (!rst_n_i)
    sweep_done_o |-> !step_valid_o
                  && $past(step_valid_o && step_addr_o == addr_t'(`NUM_STEPS - 1)));

endmodule

`default_nettype wire

/* test/clock_gen.sv */
// 100 MHz adc_clk source with a 5 cycle synchronous reset
`timescale 1ns/10ps
`default_nettype none

module clock_gen (
  output logic adc_clk,
  output logic rst_n_o
);

  localparam int RST_CYCLES = 5;

  initial
  begin
    adc_clk = 1'b0;
    forever #5 adc_clk = ~adc_clk;   // 10 ns period
  end

  initial
  begin
    rst_n_o = 1'b0;
    repeat (RST_CYCLES) @(posedge adc_clk);
    #1 rst_n_o = 1'b1;               // released just after the edge
  end

endmodule

`default_nettype wire

/* test/sweep_analyzer_tb.sv */
// testbench for the sweep analyzer, file driven calibration, sequencing and dac checks
`timescale 1ns/10ps
`default_nettype none

`include "sweep_defs.svh"

module sweep_analyzer_tb
  import sweep_pkg::*;
();

  localparam int S_MAX       = (1 << (`SAMPLE_W-1)) - 1;
  localparam int S_MIN       = -(1 << (`SAMPLE_W-1));
  localparam int SWEEP_LIMIT = `NUM_STEPS * (`SETTLE_CYCLES + `MEASURE_CYCLES + 1) + 64;

  logic                 adc_clk, rst_n_i, start_i;
  logic [`ADC_IN_W-1:0] adc_a_i, adc_b_i;
  sample_t              ext_i;
  logic [`SAMPLE_W-1:0] dac_dat_o;
  logic                 busy_o, step_valid_o, sweep_done_o;
  addr_t                step_addr_o;
  sample_t              max_a_o, min_a_o, max_b_o, min_b_o;

  // input file columns, one entry per line
  string                v_name [$];
  logic [`ADC_IN_W-1:0] v_a [$], v_b [$];
  int                   v_ext [$], v_cal_a [$], v_cal_b [$];
  logic [`SAMPLE_W-1:0] v_code [$];
  logic [31:0]          rnd     = 32'hca294a91;

  clock_gen clock_gen_i (.adc_clk (adc_clk), .rst_n_o (rst_n_i));

  sweep_analyzer_top sweep_analyzer_top_i (
    .adc_clk (adc_clk), .rst_n_i (rst_n_i), .adc_a_i (adc_a_i), .adc_b_i (adc_b_i),
    .ext_i (ext_i), .start_i (start_i), .dac_dat_o (dac_dat_o), .busy_o (busy_o),
    .step_valid_o (step_valid_o), .step_addr_o (step_addr_o), .max_a_o (max_a_o),
    .min_a_o (min_a_o), .max_b_o (max_b_o), .min_b_o (min_b_o), .sweep_done_o (sweep_done_o)
  );

  //////////////////////////////////////////////////////////////////////
  // reference rules
  //////////////////////////////////////////////////////////////////////
  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  // raw adc word -> calibrated sample, plain integer math
  function automatic sample_t cal_model(input logic [`ADC_IN_W-1:0] raw);
    int code;
    int s;
    int v;
    code = int'(raw >> (`ADC_IN_W - `SAMPLE_W));  // reserved lsbs gone
    s    = S_MAX - (code % (S_MAX + 1));           // magnitude bits inverted
    if (code > S_MAX)
      s = s + S_MIN;                               // sign bit kept
    v = (((s - `CAL_OFFSET) * `CAL_GAIN) >>> `CAL_SHIFT) - `CAL_BIAS;
    v = (v > S_MAX) ? S_MAX : (v < S_MIN) ? S_MIN : v;
    return sample_t'(v);
  endfunction

  // neg-slope code counts down from full scale, code 0 is +8191
  function automatic logic [`SAMPLE_W-1:0] dac_code(input int x);
    int t;
    int d;
    t = (x > S_MAX) ? S_MAX : (x < S_MIN) ? S_MIN : x;
    d = S_MAX - t;
    return d[`SAMPLE_W-1:0];
  endfunction

  function automatic int dac_value(input logic [`SAMPLE_W-1:0] c);
    return S_MAX - int'(c);
  endfunction

  //////////////////////////////////////////////////////////////////////
  // checks and waits
  //////////////////////////////////////////////////////////////////////
  task automatic stop_on_error();
    $display("Regression failed");
    $fatal(1, "stopped at first error");
  endtask

  task automatic compare_sample(input string name, input sample_t exp, input sample_t act);
    if (act !== exp)
    begin
      $display("[FAIL] %s expected %0d actual %0d", name, exp, act);
      stop_on_error();
    end
  endtask

  task automatic compare_addr(input string name, input addr_t exp, input addr_t act);
    if (act !== exp)
    begin
      $display("[FAIL] %s expected %0d actual %0d", name, exp, act);
      stop_on_error();
    end
  endtask

  task automatic compare_code(input string name, input logic [`SAMPLE_W-1:0] exp,
                              input logic [`SAMPLE_W-1:0] act);
    if (act !== exp)
    begin
      $display("[FAIL] %s expected 0x%h actual 0x%h", name, exp, act);
      stop_on_error();
    end
  endtask

  task automatic compare_flag(input string name, input logic exp, input logic act);
    if (act !== exp)
    begin
      $display("[FAIL] %s expected %b actual %b", name, exp, act);
      stop_on_error();
    end
  endtask

  task automatic tick();
    @(posedge adc_clk);
    #1;                    // sample and drive just past the edge
  endtask

  task automatic read_vectors();
    int                   fd, n, e, ca, cb;
    string                line, name;
    logic [`ADC_IN_W-1:0] a, b;
    logic [`SAMPLE_W-1:0] c;
    fd = $fopen("test/sweep_input.txt", "r");
    if (fd == 0)
    begin
      $display("cannot open test/sweep_input.txt");
      stop_on_error();
    end
    while (!$feof(fd))
    begin
      line = "";
      n = $fgets(line, fd);
      if (n > 0 && line.getc(0) != "#")
      begin
        n = $sscanf(line, "%s %h %h %d %d %d %h", name, a, b, e, ca, cb, c);
        if (n == 7)
        begin
          v_name.push_back(name);
          v_a.push_back(a);
          v_b.push_back(b);
          v_ext.push_back(e);
          v_cal_a.push_back(ca);
          v_cal_b.push_back(cb);
          v_code.push_back(c);
        end
      end
    end
    $fclose(fd);
    if (v_name.size() == 0)
    begin
      $display("no test vectors found in the input file");
      stop_on_error();
    end
  endtask

  task automatic wait_idle(input string name);
    int cyc;
    for (cyc = 0; cyc < 8 && busy_o; cyc++)
      tick();
    if (busy_o)
    begin
      $display("busy_o stuck high before %s", name);
      stop_on_error();
    end
    tick();                // generator phase cleared
  endtask

  // one sweep, an extra start lands mid sweep when restart_at >= 0
  task automatic run_sweep(input string name, input sample_t exp_a, input sample_t exp_b,
                           input int restart_at);
    int   cyc;
    int   steps;
    logic done;
    steps   = 0;
    done    = 1'b0;
    start_i = 1'b1;
    tick();
    start_i = 1'b0;
    for (cyc = 0; cyc < SWEEP_LIMIT && !done; cyc++)
    begin
      tick();
      start_i = (cyc == restart_at);   // must be ignored while busy
      if (step_valid_o)
      begin
        compare_addr({name, " step_addr"}, addr_t'(steps), step_addr_o);
        compare_sample({name, " max_a"}, exp_a, max_a_o);
        compare_sample({name, " min_a"}, exp_a, min_a_o);
        compare_sample({name, " max_b"}, exp_b, max_b_o);
        compare_sample({name, " min_b"}, exp_b, min_b_o);
        steps++;
      end
      if (sweep_done_o)
      begin
        done = 1'b1;
        compare_flag({name, " busy_o at done"}, 1'b0, busy_o);
        compare_flag({name, " step_valid_o at done"}, 1'b0, step_valid_o);
        if (steps != `NUM_STEPS)
        begin
          $display("[FAIL] %s step count expected %0d actual %0d", name, `NUM_STEPS, steps);
          stop_on_error();
        end
      end
      else if (!busy_o)
      begin
        $display("busy_o fell before sweep_done_o in %s", name);
        stop_on_error();
      end
    end
    start_i = 1'b0;
    if (!done)
    begin
      $display("timeout waiting for sweep_done_o in %s", name);
      stop_on_error();
    end
  endtask

  // ext at full scale, generator swings -4096 .. 4095 on top
  task automatic check_saturation();
    int   cyc, v, hits;
    logic done;
    ext_i = sample_t'(S_MAX);
    wait_idle("dac_saturation");
    start_i = 1'b1;
    tick();
    start_i = 1'b0;
    hits = 0;
    done = 1'b0;
    for (cyc = 0; cyc < SWEEP_LIMIT && !done; cyc++)
    begin
      tick();
      v = dac_value(dac_dat_o);
      if (v < S_MAX - 4096 || v > S_MAX)
      begin
        $display("[FAIL] dac_saturation expected 4095..8191 actual %0d", v);
        stop_on_error();
      end
      if (v == S_MAX)
        hits++;            // clipped, or generator at zero
      done = sweep_done_o;
    end
    if (!done)
    begin
      $display("timeout waiting for sweep_done_o in dac_saturation");
      stop_on_error();
    end
    // non-negative half of the triangle must clip to full scale
    if (hits * 4 < cyc)
    begin
      $display("[FAIL] dac_saturation full scale cycles expected >= %0d actual %0d",
               cyc / 4, hits);
      stop_on_error();
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // test sequence
  //////////////////////////////////////////////////////////////////////
  initial
  begin
    int    i, cyc, restart;
    string name;
    adc_a_i = '0;
    adc_b_i = '0;
    ext_i   = '0;
    start_i = 1'b0;
    read_vectors();
    for (cyc = 0; cyc < 20 && !rst_n_i; cyc++)
      tick();
    if (!rst_n_i)
    begin
      $display("reset was never released");
      stop_on_error();
    end
    tick();
    compare_flag("reset busy_o", 1'b0, busy_o);
    compare_flag("reset step_valid_o", 1'b0, step_valid_o);
    compare_flag("reset sweep_done_o", 1'b0, sweep_done_o);
    compare_addr("reset step_addr_o", '0, step_addr_o);
    compare_code("reset dac_dat_o", dac_code(0), dac_dat_o);

    for (i = 0; i < v_name.size(); i++)
    begin
      name = v_name[i];
      compare_sample({name, " file cal_a"}, cal_model(v_a[i]), sample_t'(v_cal_a[i]));
      compare_sample({name, " file cal_b"}, cal_model(v_b[i]), sample_t'(v_cal_b[i]));
      compare_code({name, " file dac code"}, dac_code(v_ext[i]), v_code[i]);
      wait_idle(name);
      adc_a_i = v_a[i];
      adc_b_i = v_b[i];
      ext_i   = sample_t'(v_ext[i]);
      tick();              // one cycle dac latency
      compare_code({name, " idle dac_dat_o"}, dac_code(v_ext[i]), dac_dat_o);
      restart = -1;
      if (i % 2 == 1)
      begin
        rnd     = lcg_next(rnd);
        restart = 20 + int'(rnd % 32'd500);
      end
      run_sweep(name, cal_model(v_a[i]), cal_model(v_b[i]), restart);
    end

    check_saturation();
    $display("Regression passed");
    $finish;
  end

endmodule

`default_nettype wire

/* sweep_analyzer.f */
+incdir+hw
hw/sweep_pkg.sv
hw/adc_front_end.sv
hw/sweep_fsm.sv
hw/dwell_timer.sv
hw/phase_generator.sv
hw/peak_detector.sv
hw/dac_back_end.sv
hw/sweep_analyzer_top.sv
test/clock_gen.sv
test/sweep_analyzer_tb.sv

/* run_sim.sh */
#!/bin/sh
# build and run the sweep_analyzer testbench with Verilator
cd "$(dirname "$0")" || exit 1

TOP=sweep_analyzer_tb
LOG=sim.log

verilator --binary --timing --assert -Wno-fatal --top-module "$TOP" -f sweep_analyzer.f
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

./obj_dir/V"$TOP" > "$LOG" 2>&1
status=$?
cat "$LOG"

if grep -q "Regression failed" "$LOG"; then
  exit 1
fi
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi
exit 0

/* test/sweep_input.txt */
# name  adc_a adc_b (raw hex)  ext (dec)  cal_a cal_b (expected dec)  dac_code for ext (hex)
# each line runs one sweep with constant adc words, then an idle dac check
cal_offset    1777  11b5      0  -4096  -3096  1fff
cal_mid_high  0acc  223c    100  -1894  -5972  1f9b
cal_top       0002  0acc     -1    -16  -1894  2000
cal_sat_low   8f9c  7ffc  -2000  -8192  -8192  27cf
cal_full_neg  ffff  1777   8191  -8192  -4096  0000
cal_floor     223c  0002  -8192  -5972    -16  3fff
